//--- include/ibuf_params.svh
// Instruction buffer sizing macros
// Lane counts, queue depth and derived field widths

`ifndef IBUF_PARAMS_SVH
`define IBUF_PARAMS_SVH

// Packets offered by decode each cycle, twice the fetch width
`define IBUF_WRITE_LANES 4

// Bundle size handed to dispatch
`define IBUF_DISPATCH_LANES 4

// Number of queue entries, need not be a power of two
`define IBUF_DEPTH 12

// Slot address width
`define IBUF_INDEX_W 4

// Occupancy width, one bit wider than the index so it can hold the depth
`define IBUF_COUNT_W 5

// Dispatched lane count, 0 up to a full bundle
`define IBUF_DISP_CNT_W 3

// Opaque instruction payload carried through the queue
`define IBUF_PAYLOAD_W 32

`endif

//--- rtl/ibufPkg.sv
// Shared types for the instruction buffer
// Queue entry layout as written by decode and read by dispatch

`include "ibuf_params.svh"

package ibufPkg;

	// One decoded instruction slot
	// Flags sit above the payload so the word reads flags-first in waves
	typedef struct packed {
		// Slot holds a real instruction
		logic valid;
		// Memory ops, passed on to the load/store queue allocation
		logic isLoad;
		logic isStore;
		// Control register access, ends its bundle
		logic isCsr;
		// Instruction raised an exception in the front end, ends its bundle
		logic exception;
		// Remaining decoded fields, not interpreted here
		logic [`IBUF_PAYLOAD_W-1:0] payload;
	} ibufEntry;

endpackage

//--- rtl/ibufRamIf.sv
// Storage port bundle between pointer logic, entry array and dispatch
// Write lanes from the tail side, read lanes from the head side

`timescale 1ns/1ps

`include "ibuf_params.svh"

interface ibufRamIf;

	// Write side, one lane per decode packet
	logic [`IBUF_WRITE_LANES-1:0] wrEn;
	logic [`IBUF_INDEX_W-1:0]     wrAddr [0:`IBUF_WRITE_LANES-1];
	ibufPkg::ibufEntry            wrData [0:`IBUF_WRITE_LANES-1];

	// Read side, one lane per dispatch slot
	logic [`IBUF_INDEX_W-1:0]     rdAddr [0:`IBUF_DISPATCH_LANES-1];
	ibufPkg::ibufEntry            rdData [0:`IBUF_DISPATCH_LANES-1];

	// Pointer block owns every address and the write data
	modport ctrl (
		output wrEn,
		output wrAddr,
		output wrData,
		output rdAddr
	);

	// Entry array
	modport ram (
		input  wrEn,
		input  wrAddr,
		input  wrData,
		input  rdAddr,
		output rdData
	);

	// Dispatch only looks at the head entries
	modport reader (
		input  rdData
	);

endinterface

//--- rtl/ibufRam.sv
// Multiported entry array for the instruction buffer
// Edge-triggered write lanes, combinational read lanes

`timescale 1ns/1ps

`include "ibuf_params.svh"

module ibufRam (
	input  logic  clk,
	ibufRamIf.ram ramPort
);

	localparam int WriteLanes = `IBUF_WRITE_LANES;
	localparam int DispLanes  = `IBUF_DISPATCH_LANES;
	localparam int Depth      = `IBUF_DEPTH;

	ibufPkg::ibufEntry mem [0:Depth-1];

	// Two enabled lanes aimed at one slot this cycle
	logic wrConflict;

	// All enabled lanes land at the same edge
	// Compaction upstream keeps their slots distinct
	always_ff @(posedge clk)
	begin
		for (int w = 0; w < WriteLanes; w++)
		begin
			if (ramPort.wrEn[w])
			begin
				mem[ramPort.wrAddr[w]] <= ramPort.wrData[w];
			end
		end
	end

	// Head entries visible in the same cycle
	always_comb
	begin
		for (int r = 0; r < DispLanes; r++)
		begin
			ramPort.rdData[r] = mem[ramPort.rdAddr[r]];
		end
	end

	// Pairwise compare of enabled write addresses
	always_comb
	begin
		wrConflict = 1'b0;
		for (int a = 0; a < WriteLanes; a++)
		begin
			for (int b = a + 1; b < WriteLanes; b++)
			begin
				if (ramPort.wrEn[a] && ramPort.wrEn[b] &&
					(ramPort.wrAddr[a] == ramPort.wrAddr[b]))
				begin
					wrConflict = 1'b1;
				end
			end
		end
	end

	// A collision would silently drop a packet written by the pointer block
	noWriteCollision: assert property (@(posedge clk) !wrConflict)
		else $error("ibufRam: two write lanes target one slot");

endmodule

//--- rtl/ibufPointers.sv
// Head, tail and occupancy tracking for the instruction buffer
// Compacting write slot allocation, head-relative read addresses, full flag

`timescale 1ns/1ps

`include "ibuf_params.svh"

module ibufPointers (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        flush_i,
	input  logic                        decodeReady_i,
	input  ibufPkg::ibufEntry           fetchPkt_i [0:`IBUF_WRITE_LANES-1],
	input  logic [`IBUF_DISP_CNT_W-1:0] dispatchedCount_i,
	output logic [`IBUF_COUNT_W-1:0]    instCount_o,
	output logic                        bufferFull_o,
	ibufRamIf.ctrl                      ramPort
);

	localparam int WriteLanes = `IBUF_WRITE_LANES;
	localparam int DispLanes  = `IBUF_DISPATCH_LANES;
	localparam int IndexW     = `IBUF_INDEX_W;
	localparam int CountW     = `IBUF_COUNT_W;
	localparam logic [CountW-1:0] Depth     = CountW'(`IBUF_DEPTH);
	// Room must remain for a whole set of write lanes
	localparam logic [CountW-1:0] FullLevel = CountW'(`IBUF_DEPTH - `IBUF_WRITE_LANES);

	logic [IndexW-1:0]     headPtr;
	logic [IndexW-1:0]     tailPtr;
	logic [CountW-1:0]     instCount;

	logic [CountW-1:0]     headSum;
	logic [CountW-1:0]     tailSum;
	logic [CountW-1:0]     numWrites;
	logic [CountW-1:0]     countNext;
	logic [WriteLanes-1:0] wrEn;
	logic                  accept;

	// Explicit wrap for a non power of two depth
	// Inputs never reach twice the depth, so one subtract is enough
	function automatic logic [IndexW-1:0] wrapIdx(input logic [CountW-1:0] sum);
		logic [CountW-1:0] wrapped;
		wrapped = sum;
		if (sum >= Depth)
		begin
			wrapped = sum - Depth;
		end
		return wrapped[IndexW-1:0];
	endfunction

	// Full looks at the registered count only, no same-cycle dispatch credit
	assign bufferFull_o = (instCount > FullLevel);
	// Whole packet group or nothing
	assign accept       = decodeReady_i & ~bufferFull_o;

	// Valid lanes take consecutive slots from the tail, invalid lanes skipped
	always_comb
	begin
		logic [CountW-1:0] slot;
		slot = CountW'(tailPtr);
		for (int i = 0; i < WriteLanes; i++)
		begin
			ramPort.wrAddr[i] = wrapIdx(slot);
			ramPort.wrData[i] = fetchPkt_i[i];
			wrEn[i]           = accept & fetchPkt_i[i].valid;
			slot              = slot + CountW'(fetchPkt_i[i].valid);
		end
	end

	assign ramPort.wrEn = wrEn;

	// Bundle read window starts at the head
	always_comb
	begin
		for (int i = 0; i < DispLanes; i++)
		begin
			ramPort.rdAddr[i] = wrapIdx(CountW'(headPtr) + CountW'(i));
		end
	end

	// Entries actually written this cycle
	always_comb
	begin
		numWrites = '0;
		for (int i = 0; i < WriteLanes; i++)
		begin
			numWrites = numWrites + CountW'(wrEn[i]);
		end
	end

	assign headSum   = CountW'(headPtr) + CountW'(dispatchedCount_i);
	assign tailSum   = CountW'(tailPtr) + numWrites;
	// Dispatch count is already zero when dispatch is not ready
	assign countNext = instCount + numWrites - CountW'(dispatchedCount_i);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			headPtr   <= '0;
			tailPtr   <= '0;
			instCount <= '0;
		end
		else if (flush_i)
		begin
			// Misprediction drops everything, stale slots become unreachable
			headPtr   <= '0;
			tailPtr   <= '0;
			instCount <= '0;
		end
		else
		begin
			headPtr   <= wrapIdx(headSum);
			tailPtr   <= wrapIdx(tailSum);
			instCount <= countNext;
		end
	end

	assign instCount_o = instCount;

	// Full threshold plus dispatch accounting must keep occupancy bounded
	countInRange: assert property (@(posedge clk) disable iff (reset) instCount <= Depth)
		else $error("ibufPointers: occupancy above depth");

	// The array must never see a write while fetch is being told to hold
	noWriteWhenFull: assert property (@(posedge clk) disable iff (reset)
		bufferFull_o |-> (ramPort.wrEn == '0))
		else $error("ibufPointers: write enabled while full");

endmodule

//--- rtl/ibufDispatch.sv
// Dispatch side of the instruction buffer
// Bundle readiness, CSR/exception bundle cut and hold flags, output squash

`timescale 1ns/1ps

`include "ibuf_params.svh"

module ibufDispatch (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        flush_i,
	input  logic                        stall_i,
	input  logic                        commitCsr_i,
	input  logic [`IBUF_COUNT_W-1:0]    instCount_i,
	output logic                        bufferReady_o,
	output logic                        csrHold_o,
	output ibufPkg::ibufEntry           dispatchPkt_o [0:`IBUF_DISPATCH_LANES-1],
	output logic [`IBUF_DISP_CNT_W-1:0] dispatchedCount_o,
	ibufRamIf.reader                    ramPort
);

	localparam int DispLanes = `IBUF_DISPATCH_LANES;
	localparam int CountW    = `IBUF_COUNT_W;
	localparam int DispCntW  = `IBUF_DISP_CNT_W;

	// Lane lies inside the occupied region
	logic [DispLanes-1:0] inCount;
	// Lane survives the CSR/exception cut
	logic [DispLanes-1:0] laneMask;
	// Lane leaves the buffer this cycle
	logic [DispLanes-1:0] laneFire;
	logic [DispLanes-1:0] csrLane;
	logic [DispLanes-1:0] excLane;

	logic                 csrHold;
	logic                 excHold;
	logic                 csrFired;
	logic                 excFired;

	always_comb
	begin
		for (int i = 0; i < DispLanes; i++)
		begin
			inCount[i] = (instCount_i > CountW'(i));
		end
	end

	// Only a full bundle goes out, and nothing while a hold is pending
	assign bufferReady_o = (instCount_i >= CountW'(DispLanes)) & ~stall_i &
		~csrHold & ~excHold;

	// Lane 0 always goes; a later lane goes only if the one before went
	// and was neither CSR nor excepting, so the first such lane ends the bundle
	always_comb
	begin
		laneMask[0] = 1'b1;
		for (int i = 1; i < DispLanes; i++)
		begin
			laneMask[i] = laneMask[i-1] & inCount[i-1] &
				~(ramPort.rdData[i-1].isCsr | ramPort.rdData[i-1].exception);
		end
	end

	// Payload passes untouched; every flag gated by ready and lane mask
	always_comb
	begin
		logic gate;
		for (int i = 0; i < DispLanes; i++)
		begin
			gate        = bufferReady_o & laneMask[i];
			laneFire[i] = gate & inCount[i] & ramPort.rdData[i].valid;

			dispatchPkt_o[i]           = ramPort.rdData[i];
			dispatchPkt_o[i].valid     = laneFire[i];
			dispatchPkt_o[i].isLoad    = gate & ramPort.rdData[i].isLoad;
			dispatchPkt_o[i].isStore   = gate & ramPort.rdData[i].isStore;
			dispatchPkt_o[i].isCsr     = gate & ramPort.rdData[i].isCsr;
			dispatchPkt_o[i].exception = gate & ramPort.rdData[i].exception;

			csrLane[i] = laneFire[i] & ramPort.rdData[i].isCsr;
			excLane[i] = laneFire[i] & ramPort.rdData[i].exception;
		end
	end

	// Head and count advance by this much at the next edge
	always_comb
	begin
		dispatchedCount_o = '0;
		for (int i = 0; i < DispLanes; i++)
		begin
			dispatchedCount_o = dispatchedCount_o + DispCntW'(laneFire[i]);
		end
	end

	assign csrFired = |csrLane;
	assign excFired = |excLane;

	// CSR hold waits for the CSR to commit, clear wins over a new set
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			csrHold <= 1'b0;
		end
		else if (flush_i | commitCsr_i)
		begin
			csrHold <= 1'b0;
		end
		else if (csrFired)
		begin
			csrHold <= 1'b1;
		end
	end

	// Exception hold waits for the redirect flush
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			excHold <= 1'b0;
		end
		else if (flush_i)
		begin
			excHold <= 1'b0;
		end
		else if (excFired)
		begin
			excHold <= 1'b1;
		end
	end

	// Fetch-side view of either hold
	assign csrHold_o = csrHold | excHold;

	// Back-pressure from rename must keep every lane quiet
	noDispatchInStall: assert property (@(posedge clk) disable iff (reset)
		stall_i |-> (laneFire == '0))
		else $error("ibufDispatch: lane valid during stall");

endmodule

//--- rtl/ibufTop.sv
// Instruction buffer top level
// Connects pointer logic, entry array and dispatch through the storage bus

`timescale 1ns/1ps

`include "ibuf_params.svh"

module ibufTop (
	input  logic              clk,
	input  logic              reset,
	// Misprediction, empties the queue
	input  logic              flush_i,
	// Back-pressure from rename and issue
	input  logic              stall_i,
	// Releases the CSR hold
	input  logic              commitCsr_i,
	input  logic              decodeReady_i,
	input  ibufPkg::ibufEntry fetchPkt_i [0:`IBUF_WRITE_LANES-1],
	// Tells fetch to hold
	output logic              bufferFull_o,
	// A bundle is on dispatchPkt_o this cycle
	output logic              bufferReady_o,
	output logic              csrHold_o,
	output ibufPkg::ibufEntry dispatchPkt_o [0:`IBUF_DISPATCH_LANES-1]
);

	logic [`IBUF_COUNT_W-1:0]    instCount;
	logic [`IBUF_DISP_CNT_W-1:0] dispatchedCount;

	ibufRamIf ramBus ();

	// Tail side, head side addressing
	ibufPointers u_ibufPointers (
		.clk               (clk),
		.reset             (reset),
		.flush_i           (flush_i),
		.decodeReady_i     (decodeReady_i),
		.fetchPkt_i        (fetchPkt_i),
		.dispatchedCount_i (dispatchedCount),
		.instCount_o       (instCount),
		.bufferFull_o      (bufferFull_o),
		.ramPort           (ramBus.ctrl)
	);

	ibufRam u_ibufRam (
		.clk     (clk),
		.ramPort (ramBus.ram)
	);

	// Bundle build and serialization holds
	ibufDispatch u_ibufDispatch (
		.clk               (clk),
		.reset             (reset),
		.flush_i           (flush_i),
		.stall_i           (stall_i),
		.commitCsr_i       (commitCsr_i),
		.instCount_i       (instCount),
		.bufferReady_o     (bufferReady_o),
		.csrHold_o         (csrHold_o),
		.dispatchPkt_o     (dispatchPkt_o),
		.dispatchedCount_o (dispatchedCount),
		.ramPort           (ramBus.reader)
	);

endmodule

//--- dv/ibufTb.sv
// Testbench for the instruction buffer
// Directed and random traffic, queue reference model, per-cycle compare, watchdog

`timescale 1ns/1ps

`include "ibuf_params.svh"

module ibufTb;

	localparam int WriteLanes = `IBUF_WRITE_LANES;
	localparam int DispLanes  = `IBUF_DISPATCH_LANES;
	localparam int PayloadW   = `IBUF_PAYLOAD_W;
	localparam int ClkPeriod  = 100;
	// Reset, then the driven cycles of the five tests, each with one wrap-up cycle
	localparam int TestCycles   = 2 + 61 + 15 + 16 + 16 + 21;
	localparam int MarginCycles = 40;

	// What the buffer should show in one cycle
	typedef struct packed {
		logic                                         full;
		logic                                         ready;
		logic [`IBUF_DISP_CNT_W-1:0]                  fired;
		ibufPkg::ibufEntry [`IBUF_DISPATCH_LANES-1:0] pkt;
	} expectedOutputs;

	logic              clk;
	logic              reset;
	logic              flush;
	logic              stall;
	logic              commitCsr;
	logic              decodeReady;
	ibufPkg::ibufEntry fetchPkt [0:`IBUF_WRITE_LANES-1];
	logic              bufferFull;
	logic              bufferReady;
	logic              csrHold;
	ibufPkg::ibufEntry dispatchPkt [0:`IBUF_DISPATCH_LANES-1];

	// Model state, entries in queue order from the head
	ibufPkg::ibufEntry modelQ [$];
	logic              modelCsrHold;
	logic              modelExcHold;
	int                errorCount  = 0;
	int                testsPassed = 0;
	int                testsFailed = 0;

	ibufTop u_ibufTop (
		.clk           (clk),
		.reset         (reset),
		.flush_i       (flush),
		.stall_i       (stall),
		.commitCsr_i   (commitCsr),
		.decodeReady_i (decodeReady),
		.fetchPkt_i    (fetchPkt),
		.bufferFull_o  (bufferFull),
		.bufferReady_o (bufferReady),
		.csrHold_o     (csrHold),
		.dispatchPkt_o (dispatchPkt)
	);

	initial
	begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	initial
	begin
		#((TestCycles + MarginCycles) * ClkPeriod);
		$display("Timeout: the tests did not finish in the expected number of cycles");
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [4:0] entryFlags(input ibufPkg::ibufEntry e);
		return {e.valid, e.isLoad, e.isStore, e.isCsr, e.exception};
	endfunction

	// Full from occupancy alone, ready needs a whole bundle, no stall, no hold
	// Lanes go out from the head until the first CSR or excepting entry
	function automatic expectedOutputs ibufExpect(input ibufPkg::ibufEntry q [$],
		input logic csrHoldIn, input logic excHoldIn, input logic stallIn);
		expectedOutputs res;
		logic           open;
		res       = '0;
		res.full  = (q.size() > `IBUF_DEPTH - WriteLanes);
		res.ready = (q.size() >= DispLanes) && !stallIn && !csrHoldIn && !excHoldIn;
		open      = res.ready;
		for (int i = 0; i < DispLanes; i++)
		begin
			if (open)
			begin
				res.pkt[i] = q[i];
				res.fired  = res.fired + 1'b1;
				open       = !(q[i].isCsr || q[i].exception);
			end
		end
		return res;
	endfunction

	// Compare mid-cycle, then advance the model to match the coming edge
	always @(negedge clk)
	begin
		expectedOutputs want;
		logic           csrFired;
		logic           excFired;
		if (reset)
		begin
			modelQ.delete();
			modelCsrHold = 1'b0;
			modelExcHold = 1'b0;
		end
		else
		begin
			want = ibufExpect(modelQ, modelCsrHold, modelExcHold, stall);
			assert (bufferFull == want.full) else
			begin
				$display("[FAIL] bufferFull_o expected %h got %h", want.full, bufferFull);
				errorCount++;
			end
			assert (bufferReady == want.ready) else
			begin
				$display("[FAIL] bufferReady_o expected %h got %h", want.ready, bufferReady);
				errorCount++;
			end
			assert (csrHold == (modelCsrHold | modelExcHold)) else
			begin
				$display("[FAIL] csrHold_o expected %h got %h", modelCsrHold | modelExcHold,
					csrHold);
				errorCount++;
			end
			for (int i = 0; i < DispLanes; i++)
			begin
				assert (entryFlags(dispatchPkt[i]) == entryFlags(want.pkt[i])) else
				begin
					$display("[FAIL] dispatchPkt_o[%0d] flags expected %h got %h", i,
						entryFlags(want.pkt[i]), entryFlags(dispatchPkt[i]));
					errorCount++;
				end
				// Payload of a squashed lane is stale storage
				assert (!want.pkt[i].valid || dispatchPkt[i].payload == want.pkt[i].payload)
				else
				begin
					$display("[FAIL] dispatchPkt_o[%0d].payload expected %h got %h", i,
						want.pkt[i].payload, dispatchPkt[i].payload);
					errorCount++;
				end
			end
			if (flush)
			begin
				modelQ.delete();
				modelCsrHold = 1'b0;
				modelExcHold = 1'b0;
			end
			else
			begin
				csrFired = 1'b0;
				excFired = 1'b0;
				for (int i = 0; i < int'(want.fired); i++)
				begin
					csrFired = csrFired | modelQ[0].isCsr;
					excFired = excFired | modelQ[0].exception;
					void'(modelQ.pop_front());
				end
				// Whole group accepted or none, invalid lanes dropped
				for (int w = 0; w < WriteLanes; w++)
				begin
					if (decodeReady && !want.full && fetchPkt[w].valid)
						modelQ.push_back(fetchPkt[w]);
				end
				if (commitCsr)
					modelCsrHold = 1'b0;
				else if (csrFired)
					modelCsrHold = 1'b1;
				if (excFired)
					modelExcHold = 1'b1;
			end
		end
	end

	task automatic driveCycle(
		input logic [`IBUF_WRITE_LANES-1:0] laneValid,
		input logic [`IBUF_WRITE_LANES-1:0] laneCsr,
		input logic [`IBUF_WRITE_LANES-1:0] laneExc,
		input logic                         readyIn,
		input logic                         stallIn,
		input logic                         commitIn,
		input logic                         flushIn
	);
		ibufPkg::ibufEntry pkt;
		@(posedge clk);
		for (int w = 0; w < WriteLanes; w++)
		begin
			pkt.valid     = laneValid[w];
			pkt.isLoad    = 1'($urandom_range(0, 1));
			pkt.isStore   = 1'($urandom_range(0, 1));
			pkt.isCsr     = laneCsr[w];
			pkt.exception = laneExc[w];
			pkt.payload   = PayloadW'($urandom);
			fetchPkt[w] <= pkt;
		end
		decodeReady <= readyIn;
		stall       <= stallIn;
		commitCsr   <= commitIn;
		flush       <= flushIn;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) driveCycle('0, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
	endtask

	task automatic flushCycle();
		driveCycle('0, '0, '0, 1'b1, 1'b0, 1'b0, 1'b1);
	endtask

	task automatic checkHoldState(input logic expectHold, input string when);
		@(negedge clk);
		#1;
		assert (csrHold == expectHold) else
		begin
			$display("[FAIL] csrHold_o %s expected %h got %h", when, expectHold, csrHold);
			errorCount++;
		end
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		@(negedge clk);
		#1;
		if (errorCount == errorsBefore)
		begin
			testsPassed++;
			$display("Test %s: ok", name);
		end
		else
		begin
			testsFailed++;
			$display("Test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	initial
	begin
		int errorsBefore;
		void'($urandom(32'hdb64));
		reset       = 1'b1;
		flush       = 1'b0;
		stall       = 1'b0;
		commitCsr   = 1'b0;
		decodeReady = 1'b0;
		for (int w = 0; w < WriteLanes; w++)
			fetchPkt[w] = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Random lane masks, head and tail wrap many times at depth 12
		errorsBefore = errorCount;
		repeat (60) driveCycle(WriteLanes'($urandom_range(0, (1 << WriteLanes) - 1)), '0, '0,
			$urandom_range(0, 7) != 0, 1'b0, 1'b0, 1'b0);
		finishTest("order and packing", errorsBefore);

		// Three single entries sit below the bundle size, the fourth releases them
		errorsBefore = errorCount;
		flushCycle();
		repeat (3) driveCycle(4'b0001, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		idleCycles(5);
		driveCycle(4'b0010, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		idleCycles(4);
		finishTest("bundle gating", errorsBefore);

		// Fill under stall until full, then drain
		errorsBefore = errorCount;
		flushCycle();
		repeat (6) driveCycle('1, '0, '0, 1'b1, 1'b1, 1'b0, 1'b0);
		idleCycles(8);
		finishTest("full and back-pressure", errorsBefore);

		// CSR in lane 1 cuts the first bundle
		errorsBefore = errorCount;
		flushCycle();
		driveCycle('1, 4'b0010, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		driveCycle('1, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		idleCycles(5);
		checkHoldState(1'b1, "before commit");
		driveCycle('0, '0, '0, 1'b1, 1'b0, 1'b1, 1'b0);
		idleCycles(6);
		checkHoldState(1'b0, "after commit");
		finishTest("CSR serialization", errorsBefore);

		// Exception in lane 2, commit leaves the hold, flush clears it
		errorsBefore = errorCount;
		flushCycle();
		driveCycle('1, '0, 4'b0100, 1'b1, 1'b0, 1'b0, 1'b0);
		driveCycle('1, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		idleCycles(4);
		driveCycle('0, '0, '0, 1'b1, 1'b0, 1'b1, 1'b0);
		idleCycles(2);
		checkHoldState(1'b1, "after commit with exception pending");
		flushCycle();
		idleCycles(4);
		checkHoldState(1'b0, "after flush");
		driveCycle('1, '0, '0, 1'b1, 1'b0, 1'b0, 1'b0);
		idleCycles(4);
		finishTest("exception serialization and flush", errorsBefore);

		$display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
			testsPassed, testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- ibufTop.f
+incdir+include
rtl/ibufPkg.sv
rtl/ibufRamIf.sv
rtl/ibufRam.sv
rtl/ibufPointers.sv
rtl/ibufDispatch.sv
rtl/ibufTop.sv
dv/ibufTb.sv

//--- run.sh
#!/bin/sh
# Build the instruction buffer testbench with Verilator, run it, scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f ibufTop.f --top-module ibufTb -o ibufSim

status=0
./obj_dir/ibufSim > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "SIMULATION PASSED" sim.log; then
	echo "Simulation did not run to completion"
	exit 1
fi
